//--- verilog/lcd_bus_pkg.sv
package lcd_bus_pkg;

	// bus data and addressing widths
	typedef logic [7:0] lcd_byte_t;        // one byte on the parallel bus
	typedef logic [6:0] lcd_addr_t;        // display data address
	typedef logic [6:0] lcd_cfg_t;         // init configuration bits

	// command bytes shared by decode, execute and result
	localparam lcd_byte_t CMD_CLEAR     = 8'h01;
	localparam lcd_byte_t CMD_HOME      = 8'h02;  // bit 0 is don't care
	localparam lcd_byte_t CMD_SET_DDRAM = 8'h80;  // address goes in bits 6..0

	// last address of a two line display before the counter wraps
	localparam lcd_addr_t ADDR_LAST = 7'd79;

	// one complete bus transfer
	typedef struct packed {
		logic      rs;                     // 1 selects data register
		logic      rw;                     // 1 is a read
		lcd_byte_t data;
	} lcd_word_t;

	// execute stage FSM
	typedef enum logic [1:0] {
		POWER_UP,                          // supply settling wait
		INIT,                              // four step init sequence
		IDLE,
		XFER                               // one timed enable pulse
	} bus_state_t;

	// cfg field layout
	//   6..5  function set (lines, font)
	//   4..2  display on, cursor on, blink
	//   1..0  entry mode (increment, shift)
	localparam int CFG_FUNC_HI  = 6;
	localparam int CFG_FUNC_LO  = 5;
	localparam int CFG_DISP_HI  = 4;
	localparam int CFG_DISP_LO  = 2;
	localparam int CFG_ENTRY_HI = 1;
	localparam int CFG_ENTRY_LO = 0;

endpackage

//--- verilog/lcd_host_pkg.sv
package lcd_host_pkg;

	import lcd_bus_pkg::*;

	// host request opcodes
	typedef enum logic [2:0] {
		OP_WRITE_CHAR  = 3'd0,   // arg is the character code
		OP_CLEAR       = 3'd1,
		OP_HOME        = 3'd2,
		OP_SET_ADDR    = 3'd3,   // arg bits 6..0 are the address
		OP_READ_STATUS = 3'd4,
		OP_RAW_CMD     = 3'd5    // arg goes out unchanged as a command
	} host_op_t;

	// one request from the host side
	typedef struct packed {
		host_op_t  op;
		lcd_byte_t arg;
	} host_req_t;

	// codes 6 and 7 are unused and decode treats them as raw commands

endpackage

//--- verilog/lcd_cmd_decode.sv
`timescale 1ns/1ps

module lcd_cmd_decode
	import lcd_bus_pkg::*;
	import lcd_host_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  host_req_t req,
	input  logic      req_valid,
	input  logic      take,
	input  logic      busy,
	output lcd_word_t word,
	output logic      word_valid,
	output logic      ready,
	output logic      req_dropped
);

	lcd_word_t word_q;
	logic      valid_q;
	logic      dropped_q;
	logic      accept;
	lcd_word_t mapped;

	// opcode to bus word
	function automatic lcd_word_t map_req(input host_req_t r);
		lcd_word_t w;
		w.rs   = 1'b0;
		w.rw   = 1'b0;
		w.data = r.arg;             // raw command by default
		case (r.op)
			OP_WRITE_CHAR: begin
				w.rs = 1'b1;
			end
			OP_CLEAR: begin
				w.data = CMD_CLEAR;
			end
			OP_HOME: begin
				w.data = CMD_HOME;
			end
			OP_SET_ADDR: begin
				w.data = CMD_SET_DDRAM | {1'b0, r.arg[6:0]};
			end
			OP_READ_STATUS: begin
				w.rw   = 1'b1;
				w.data = '0;
			end
			default: begin
				w.data = r.arg;
			end
		endcase
		return w;
	endfunction

	assign mapped = map_req(req);

	// a free slot, or the held word leaving this cycle
	assign accept = req_valid && (!valid_q || take);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q   <= 1'b0;
			dropped_q <= 1'b0;
		end else begin
			dropped_q <= req_valid && !accept;
			if (accept)
				valid_q <= 1'b1;
			else if (take)
				valid_q <= 1'b0;
		end
	end

	// word held until take
	always_ff @(posedge clk) begin
		if (accept)
			word_q <= mapped;
	end

	assign word        = word_q;
	assign word_valid  = valid_q;
	assign req_dropped = dropped_q;
	assign ready       = !valid_q && !busy;  // nothing held and execute idle

endmodule

//--- verilog/lcd_bus_timing.sv
`timescale 1ns/1ps

module lcd_bus_timing
	import lcd_bus_pkg::*;
#(
	parameter int CYCLES_PER_US = 1
) (
	input  logic      clk,
	input  logic      rst_n,
	input  lcd_cfg_t  init_cfg,
	input  lcd_word_t word,
	input  logic      word_valid,
	output logic      take,
	output logic      busy,
	output logic      e,
	output logic      rs,
	output logic      rw,
	output lcd_byte_t lcd_data,
	output logic      done,
	output lcd_word_t done_word
);

	localparam int T_POWER_UP = 500 * CYCLES_PER_US;
	localparam int T_INIT     = 440 * CYCLES_PER_US;
	localparam int T_E_INIT   = 10 * CYCLES_PER_US;   // init pulse width
	localparam int SLOT_DISP  = 60 * CYCLES_PER_US;
	localparam int SLOT_CLEAR = 120 * CYCLES_PER_US;
	localparam int SLOT_ENTRY = 330 * CYCLES_PER_US;
	localparam int T_E_SETUP  = CYCLES_PER_US;        // rs/rw/data ahead of e
	localparam int T_E_END    = 14 * CYCLES_PER_US;   // e high for 13 us
	localparam int T_XFER     = 50 * CYCLES_PER_US;
	localparam int CNT_W      = $clog2(T_POWER_UP + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	bus_state_t state;
	cnt_t       cnt;
	cnt_t       cnt_inc;
	cnt_t       init_pos;
	logic       init_pulse;
	lcd_byte_t  init_byte;
	lcd_word_t  bus_q;
	logic       e_q;
	logic       busy_q;
	logic       done_q;

	function automatic logic in_window(input cnt_t c, input int start);
		return (c >= start) && (c < start + T_E_INIT);
	endfunction

	assign cnt_inc = cnt + 1'b1;

	// e and data for the init slot that the next count falls in
	always_comb begin
		init_pos   = (state == INIT) ? cnt_inc : '0;
		init_pulse = 1'b1;
		if (in_window(init_pos, 0))
			init_byte = {4'b0011, init_cfg[CFG_FUNC_HI:CFG_FUNC_LO], 2'b00};
		else if (in_window(init_pos, SLOT_DISP))
			init_byte = {5'b00001, init_cfg[CFG_DISP_HI:CFG_DISP_LO]};
		else if (in_window(init_pos, SLOT_CLEAR))
			init_byte = CMD_CLEAR;
		else if (in_window(init_pos, SLOT_ENTRY))
			init_byte = {6'b000001, init_cfg[CFG_ENTRY_HI:CFG_ENTRY_LO]};
		else begin
			init_pulse = 1'b0;
			init_byte  = '0;             // wait between slots
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= POWER_UP;
			cnt    <= '0;
			e_q    <= 1'b0;
			busy_q <= 1'b1;
			done_q <= 1'b0;
			bus_q  <= '0;
		end else begin
			done_q <= 1'b0;
			case (state)
				POWER_UP: begin
					if (cnt == cnt_t'(T_POWER_UP)) begin
						state <= INIT;
						cnt   <= '0;
						e_q   <= init_pulse;    // first slot starts at once
						bus_q <= '{rs: 1'b0, rw: 1'b0, data: init_byte};
					end else begin
						cnt <= cnt_inc;
					end
				end
				INIT: begin
					if (cnt == cnt_t'(T_INIT - 1)) begin
						state  <= IDLE;
						busy_q <= 1'b0;
						e_q    <= 1'b0;
						bus_q  <= '0;
					end else begin
						cnt        <= cnt_inc;
						e_q        <= init_pulse;
						bus_q.data <= init_byte;
					end
				end
				IDLE: begin
					if (take) begin
						state  <= XFER;
						cnt    <= '0;
						busy_q <= 1'b1;
						bus_q  <= word;           // held for the whole pulse
					end
				end
				XFER: begin
					cnt    <= cnt_inc;
					e_q    <= (cnt_inc >= T_E_SETUP) && (cnt_inc < T_E_END);
					done_q <= (cnt_inc == T_E_END);  // with the falling e
					if (cnt == cnt_t'(T_XFER - 1)) begin
						state  <= IDLE;
						cnt    <= '0;
						busy_q <= 1'b0;
						bus_q  <= '0;
					end
				end
				default: begin
					state <= POWER_UP;
				end
			endcase
		end
	end

	assign take      = (state == IDLE) && word_valid;
	assign busy      = busy_q;
	assign e         = e_q;
	assign rs        = bus_q.rs;
	assign rw        = bus_q.rw;
	assign lcd_data  = bus_q.data;
	assign done      = done_q;
	assign done_word = bus_q;        // still latched when done fires

endmodule

//--- verilog/lcd_cursor_track.sv
`timescale 1ns/1ps

module lcd_cursor_track
	import lcd_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      done,
	input  lcd_word_t done_word,
	input  lcd_byte_t lcd_din,
	output lcd_addr_t cursor,
	output logic      read_valid,
	output lcd_byte_t read_data
);

	lcd_addr_t cursor_q;
	logic      read_valid_q;
	lcd_byte_t read_data_q;
	logic      is_write;
	logic      is_read;
	logic      is_clear_home;
	logic      is_set_addr;

	// classify the finished transfer
	assign is_read       = done_word.rw;
	assign is_write      = done_word.rs && !done_word.rw;
	assign is_clear_home = !done_word.rs && !done_word.rw &&
		((done_word.data == CMD_CLEAR) || (done_word.data[7:1] == CMD_HOME[7:1]));
	assign is_set_addr   = !done_word.rs && !done_word.rw && done_word.data[7];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cursor_q     <= '0;
			read_valid_q <= 1'b0;
		end else begin
			read_valid_q <= done && is_read;
			if (done) begin
				if (is_clear_home)
					cursor_q <= '0;
				else if (is_set_addr)
					cursor_q <= done_word.data[6:0];
				else if (is_write)
					cursor_q <= (cursor_q == ADDR_LAST) ? '0 : cursor_q + 1'b1;
			end
		end
	end

	// display drives lcd_din until e has fallen
	always_ff @(posedge clk) begin
		if (done && is_read)
			read_data_q <= lcd_din;
	end

	assign cursor     = cursor_q;
	assign read_valid = read_valid_q;
	assign read_data  = read_data_q;

endmodule

//--- verilog/lcd_ctrl_top.sv
`timescale 1ns/1ps

module lcd_ctrl_top
	import lcd_bus_pkg::*;
	import lcd_host_pkg::*;
#(
	parameter int CYCLES_PER_US = 50
) (
	input  logic      clk,
	input  logic      rst_n,
	input  host_req_t req,
	input  logic      req_valid,
	input  lcd_cfg_t  init_cfg,
	input  lcd_byte_t lcd_din,
	output logic      e,
	output logic      rs,
	output logic      rw,
	output lcd_byte_t lcd_data,
	output logic      busy,
	output logic      ready,
	output logic      req_dropped,
	output lcd_addr_t cursor,
	output logic      read_valid,
	output lcd_byte_t read_data
);

	lcd_word_t word;
	logic      word_valid;
	logic      take;
	logic      done;
	lcd_word_t done_word;

	lcd_cmd_decode lcd_cmd_decode_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.req_valid   (req_valid),
		.take        (take),
		.busy        (busy),
		.word        (word),
		.word_valid  (word_valid),
		.ready       (ready),
		.req_dropped (req_dropped)
	);

	lcd_bus_timing #(
		.CYCLES_PER_US (CYCLES_PER_US)
	) lcd_bus_timing_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.init_cfg   (init_cfg),
		.word       (word),
		.word_valid (word_valid),
		.take       (take),
		.busy       (busy),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.done       (done),
		.done_word  (done_word)
	);

	lcd_cursor_track lcd_cursor_track_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.done       (done),
		.done_word  (done_word),
		.lcd_din    (lcd_din),
		.cursor     (cursor),
		.read_valid (read_valid),
		.read_data  (read_data)
	);

endmodule

//--- verification/lcd_ctrl_asserts.sv
`timescale 1ns/1ps

module lcd_ctrl_asserts
	import lcd_bus_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      e,
	input logic      busy,
	input logic      rs,
	input logic      rw,
	input lcd_byte_t lcd_data,
	input logic      take,
	input logic      word_valid
);

	e_only_when_busy: assert property (@(posedge clk) disable iff (!rst_n) e |-> busy)
		else $error("e high outside init or a transfer");

	// display latches the bus as e falls
	bus_stable_in_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		e && $past(e) |-> $stable({rs, rw, lcd_data}))
		else $error("rs, rw or lcd_data changed while e was high");

	// take only from an idle execute stage with a word held
	take_needs_word: assert property (@(posedge clk) disable iff (!rst_n)
		take |-> word_valid && !busy)
		else $error("take raised with no word held or while execute was busy");

endmodule

bind lcd_bus_timing lcd_ctrl_asserts lcd_ctrl_asserts_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.e          (e),
	.busy       (busy),
	.rs         (rs),
	.rw         (rw),
	.lcd_data   (lcd_data),
	.take       (take),
	.word_valid (word_valid)
);

//--- verification/lcd_ctrl_tb.sv
`timescale 1ns/1ps

module lcd_ctrl_tb
	import lcd_bus_pkg::*;
	import lcd_host_pkg::*;
();

	localparam int       CYCLES_PER_US = 1;
	localparam int       INIT_CYCLES   = 940 * CYCLES_PER_US + 1;  // release to busy low
	localparam int       E_INIT_LEN    = 10 * CYCLES_PER_US;
	localparam int       E_XFER_LEN    = 13 * CYCLES_PER_US;
	localparam int       MAX_CASES     = 64;
	localparam lcd_cfg_t CFG           = 7'h5a;  // 2 lines, display on, increment

	logic      clk = 1'b0;
	logic      rst_n;
	host_req_t req;
	logic      req_valid;
	lcd_cfg_t  init_cfg;
	lcd_byte_t lcd_din;
	logic      e;
	logic      rs;
	logic      rw;
	lcd_byte_t lcd_data;
	logic      busy;
	logic      ready;
	logic      req_dropped;
	lcd_addr_t cursor;
	logic      read_valid;
	lcd_byte_t read_data;

	logic [8*24-1:0] case_name [MAX_CASES];
	host_req_t       case_req [MAX_CASES];
	lcd_byte_t       case_din [MAX_CASES];
	lcd_word_t       case_word [MAX_CASES];     // expected bus word
	lcd_addr_t       case_cursor [MAX_CASES];
	lcd_byte_t       case_rdata [MAX_CASES];
	logic            case_drop [MAX_CASES];
	int              n_cases = 0;
	logic            load_ok = 1'b1;

	lcd_word_t       pulse_log [$];             // bus word of every e pulse
	logic            e_prev = 1'b0;
	int              e_len = 0;
	int              last_e_len = 0;
	int              drop_count = 0;
	int              read_count = 0;
	logic [8*24-1:0] cur_name;
	int              test_errs;
	int              tests_run = 0;
	int              tests_failed = 0;
	int              cycles = 0;
	int              cycle_limit = 1200;

	always #20 clk = ~clk;

	lcd_ctrl_top #(
		.CYCLES_PER_US (CYCLES_PER_US)
	) lcd_ctrl_top_i (.*);

	// bus monitor sampled mid cycle
	always @(negedge clk) begin
		if (e && !e_prev) begin
			pulse_log.push_back(lcd_word_t'{rs: rs, rw: rw, data: lcd_data});
			e_len = 1;
		end else if (e) begin
			e_len++;
		end
		if (!e && e_prev)
			last_e_len = e_len;
		if (req_dropped)
			drop_count++;
		if (read_valid)
			read_count++;
		e_prev = e;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout, no result after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic lcd_byte_t expected_init_byte(input int slot, input lcd_cfg_t cfg);
		case (slot)
			0: return 8'h30 | {4'b0, cfg[6:5], 2'b0};  // function set
			1: return 8'h08 | {5'b0, cfg[4:2]};        // display control
			2: return 8'h01;
			default: return 8'h04 | {6'b0, cfg[1:0]};  // entry mode
		endcase
	endfunction

	task automatic load_cases();
		int               fd;
		int               code;
		logic             at_end;
		logic [8*24-1:0]  tok;
		logic [8*128-1:0] rest;
		logic [7:0]       op_v;
		logic [7:0]       arg_v;
		logic [7:0]       din_v;
		logic [7:0]       rs_v;
		logic [7:0]       rw_v;
		logic [7:0]       data_v;
		logic [7:0]       cur_v;
		logic [7:0]       rd_v;
		logic [7:0]       drop_v;
		at_end = 1'b0;
		fd     = $fopen("verification/lcd_cases.txt", "r");
		if (fd == 0) begin
			load_ok = 1'b0;
		end else begin
			while (!at_end && n_cases < MAX_CASES) begin
				tok  = '0;
				code = $fscanf(fd, "%s", tok);
				if (code != 1) begin
					at_end = 1'b1;
				end else if (tok == "#") begin
					code = $fgets(rest, fd);          // column notes
				end else begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", op_v, arg_v, din_v,
						rs_v, rw_v, data_v, cur_v, rd_v, drop_v);
					if (code != 9) begin
						load_ok = 1'b0;
						at_end  = 1'b1;
					end
					case_name[n_cases]   = tok;
					case_req[n_cases]    = '{op: host_op_t'(op_v[2:0]), arg: arg_v};
					case_din[n_cases]    = din_v;
					case_word[n_cases]   = '{rs: rs_v[0], rw: rw_v[0], data: data_v};
					case_cursor[n_cases] = cur_v[6:0];
					case_rdata[n_cases]  = rd_v;
					case_drop[n_cases]   = drop_v[0];
					n_cases++;
				end
			end
			$fclose(fd);
		end
		if (n_cases == 0)
			load_ok = 1'b0;
		cycle_limit = 1200 + 80 * n_cases;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("Fail %0s %0s expected %0h actual %0h", cur_name, what, exp_v, act_v);
		test_errs++;
	endtask

	task automatic begin_test(input logic [8*24-1:0] name);
		cur_name  = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("test %0s: %0s", cur_name, (test_errs == 0) ? "ok" : "failed");
	endtask

	task automatic strobe(input host_req_t r);
		@(negedge clk);
		req       = r;
		req_valid = 1'b1;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_ready();
		while (!ready)
			@(negedge clk);
	endtask

	task automatic reset_state_test();
		logic [13:0] seen;
		begin_test("reset");
		seen = {e, lcd_ctrl_top_i.take, lcd_ctrl_top_i.done, req_dropped, read_valid,
			busy, ready, cursor};
		if (seen !== {5'b0, 1'b1, 1'b0, 7'd0})
			report_mismatch("outputs", 32'({5'b0, 1'b1, 1'b0, 7'd0}), 32'(seen));
		end_test();
	endtask

	task automatic init_sequence_test();
		int waited;
		begin_test("init");
		waited = 0;
		while (busy) begin
			@(negedge clk);
			waited++;
		end
		if (waited != INIT_CYCLES)
			report_mismatch("busy cycles", INIT_CYCLES, waited);
		if (pulse_log.size() != 4)
			report_mismatch("e pulses", 4, pulse_log.size());
		else
			for (int k = 0; k < 4; k++)
				if (pulse_log[k] !== {2'b00, expected_init_byte(k, CFG)})
					report_mismatch("init word", 32'(expected_init_byte(k, CFG)),
						32'(pulse_log[k]));
		if (last_e_len != E_INIT_LEN)
			report_mismatch("e width", E_INIT_LEN, last_e_len);
		end_test();
	endtask

	task automatic run_case(input int idx);
		int        base;
		int        drops;
		int        reads;
		host_req_t second;
		begin_test(case_name[idx]);
		second     = case_req[idx];
		second.arg = ~second.arg;
		wait_ready();
		lcd_din = case_din[idx];
		drops   = drop_count;
		reads   = read_count;
		base    = pulse_log.size();
		strobe(case_req[idx]);
		if (case_drop[idx]) begin
			while (pulse_log.size() == base || e)  // first transfer keeps execute busy
				@(negedge clk);
			base = pulse_log.size();
			@(negedge clk);
			req       = case_req[idx];
			req_valid = 1'b1;
			@(negedge clk);
			req       = second;                    // collides with the held word
			@(negedge clk);
			req_valid = 1'b0;
			drops++;
		end
		wait_ready();
		@(negedge clk);
		if (pulse_log.size() != base + 1)
			report_mismatch("e pulses", base + 1, pulse_log.size());
		else if (pulse_log[base] !== case_word[idx])
			report_mismatch("bus word", 32'(case_word[idx]), 32'(pulse_log[base]));
		if (last_e_len != E_XFER_LEN)
			report_mismatch("e width", E_XFER_LEN, last_e_len);
		if (cursor !== case_cursor[idx])
			report_mismatch("cursor", 32'(case_cursor[idx]), 32'(cursor));
		if (drop_count != drops)
			report_mismatch("req_dropped pulses", drops, drop_count);
		if (case_word[idx].rw)
			reads++;
		if (read_count != reads)
			report_mismatch("read_valid pulses", reads, read_count);
		if (case_word[idx].rw && read_data !== case_rdata[idx])
			report_mismatch("read_data", 32'(case_rdata[idx]), 32'(read_data));
		end_test();
	endtask

	initial begin
		rst_n     = 1'b0;
		req       = '0;
		req_valid = 1'b0;
		init_cfg  = CFG;
		lcd_din   = '0;
		load_cases();
		if (!load_ok) begin
			$display("could not read the cases from verification/lcd_cases.txt");
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			@(negedge clk);
			reset_state_test();
			repeat (7) @(negedge clk);
			rst_n = 1'b1;
			init_sequence_test();
			for (int i = 0; i < n_cases; i++)
				run_case(i);
			$display("tests %0d passed %0d failed %0d", tests_run,
				tests_run - tests_failed, tests_failed);
			if (tests_failed == 0)
				$display("TEST RESULT: PASS");
			else
				$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule

//--- verification/lcd_cases.txt
# name op arg lcd_din rs rw data cursor read_data drop (fields after the name in hex)
# op 0 char 1 clear 2 home 3 set_addr 4 read 5 raw, drop 1 sends a colliding second request
write_h            0 48 00  1 0 48 01 00 0
write_i            0 69 00  1 0 69 02 00 0
read_status        4 ff 5c  0 1 00 02 5c 0
home               2 00 00  0 0 02 00 00 0
set_addr_40        3 40 00  0 0 c0 40 00 0
write_at_40        0 41 00  1 0 41 41 00 0
set_addr_4e        3 4e 00  0 0 ce 4e 00 0
write_at_78        0 2d 00  1 0 2d 4f 00 0
write_wrap         0 2e 00  1 0 2e 00 00 0
set_addr_mask      3 85 00  0 0 85 05 00 0
raw_shift          5 14 00  0 0 14 05 00 0
raw_set_addr       5 8a 00  0 0 8a 0a 00 0
read_status_2      4 00 a7  0 1 00 0a a7 0
clear              1 33 00  0 0 01 00 00 0
write_after_clear  0 7e 00  1 0 7e 01 00 0
drop_write         0 5a 00  1 0 5a 03 00 1
raw_home_odd       5 03 00  0 0 03 00 00 0
raw_display        5 0c 00  0 0 0c 00 00 0
set_addr_4f        3 4f 00  0 0 cf 4f 00 0
read_status_3      4 12 00  0 1 00 4f 00 0

//--- tb.f
verilog/lcd_bus_pkg.sv
verilog/lcd_host_pkg.sv
verilog/lcd_cmd_decode.sv
verilog/lcd_bus_timing.sv
verilog/lcd_cursor_track.sv
verilog/lcd_ctrl_top.sv
verification/lcd_ctrl_asserts.sv
verification/lcd_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the LCD controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module lcd_ctrl_tb -f tb.f -o lcd_ctrl_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/lcd_ctrl_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
